/* list.f */
+incdir+.
periph_bus_pkg.sv
ems_pkg.sv
io_decode_stage.sv
port_register_file.sv
ems_map_stage.sv
readback_stage.sv
periph_glue_top.sv
periph_glue_asserts.sv
tb_periph_glue.sv

/* Bender.yml */
package:
  name: periph_glue

export_include_dirs:
  - .

sources:
  - files:
      - periph_bus_pkg.sv
      - ems_pkg.sv
      - io_decode_stage.sv
      - port_register_file.sv
      - ems_map_stage.sv
      - readback_stage.sv
      - periph_glue_top.sv
  - target: test
    files:
      - periph_glue_asserts.sv
      - tb_periph_glue.sv

/* tb_periph_glue.sv */
//------------------------------
// Testbench for the peripheral glue
// Table of I/O and memory cycles
//------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module tb_periph_glue;

    localparam logic [1:0] KIND_READ  = 2'd0;
    localparam logic [1:0] KIND_WRITE = 2'd1;
    localparam logic [1:0] KIND_MEM   = 2'd2;
    localparam int RESET_CYCLES = 8;

    localparam periph_bus_pkg::io_addr_t ADDR_EMS0  = {4'h0, `PORT_EMS_BASE};
    localparam periph_bus_pkg::io_addr_t ADDR_LPT   = {4'h0, `PORT_LPT};
    localparam periph_bus_pkg::io_addr_t ADDR_PAGE  = {4'h0, `PORT_TANDY_PAGE};
    localparam periph_bus_pkg::io_addr_t ADDR_NMI   = {4'h0, `PORT_NMI_MASK};

    typedef struct {
        string                    name;
        periph_bus_pkg::io_addr_t addr;
        periph_bus_pkg::data_t    data;
        logic [1:0]               kind;
        logic                     aen_n;
        logic                     tandy;
        logic                     ems_en;
        ems_pkg::ems_base_sel_t   base_sel;
        periph_bus_pkg::data_t    exp_data;
        logic                     exp_valid;
        logic [3:0]               exp_hits;
        logic [3:0]               exp_enables;
        ems_pkg::ems_page_t [3:0] exp_pages;
    } access_t;

    logic                       clock = 1'b0;
    logic                       reset;
    periph_bus_pkg::io_addr_t   address;
    periph_bus_pkg::data_t      data;
    logic                       io_read_n;
    logic                       io_write_n;
    logic                       address_enable_n;
    logic                       tandy_video;
    logic                       ems_enabled;
    ems_pkg::ems_base_sel_t     ems_base_sel;
    periph_bus_pkg::data_t      data_out;
    logic                       data_valid;
    ems_pkg::ems_page_t [3:0]   ems_page;
    logic [3:0]                 ems_map_enable;
    logic [3:0]                 ems_window_hit;

    access_t                    accesses[$];
    access_t                    in_flight[$];
    logic                       row_aen_n;
    logic                       row_tandy;
    logic                       row_ems_en;
    ems_pkg::ems_base_sel_t     row_base_sel;
    // Map state once the row has passed the register stage
    logic [3:0]                 row_map_en;
    ems_pkg::ems_page_t [3:0]   row_pages;
    int                         seed = 32'h1d20_9796;
    int                         cycle_count = 0;
    int                         max_cycles = 0;

    periph_glue_top uut (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address),
        .data_i             (data),
        .io_read_n_i        (io_read_n),
        .io_write_n_i       (io_write_n),
        .address_enable_n_i (address_enable_n),
        .tandy_video_i      (tandy_video),
        .ems_enabled_i      (ems_enabled),
        .ems_base_sel_i     (ems_base_sel),
        .data_o             (data_out),
        .data_valid_o       (data_valid),
        .ems_page_o         (ems_page),
        .ems_map_enable_o   (ems_map_enable),
        .ems_window_hit_o   (ems_window_hit)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (max_cycles > 0 && cycle_count > max_cycles) begin
            $display("Run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic access_t make_row(input string name,
                                         input periph_bus_pkg::io_addr_t addr,
                                         input periph_bus_pkg::data_t data,
                                         input logic [1:0] kind,
                                         input periph_bus_pkg::data_t exp_data,
                                         input logic exp_valid,
                                         input logic [3:0] exp_hits);
        access_t row;
        row.name        = name;
        row.addr        = addr;
        row.data        = data;
        row.kind        = kind;
        row.aen_n       = row_aen_n;
        row.tandy       = row_tandy;
        row.ems_en      = row_ems_en;
        row.base_sel    = row_base_sel;
        row.exp_data    = exp_data;
        row.exp_valid   = exp_valid;
        row.exp_hits    = exp_hits;
        row.exp_enables = row_map_en;
        row.exp_pages   = row_pages;
        return row;
    endfunction

    task automatic read_row(input string name, input periph_bus_pkg::io_addr_t addr,
                            input periph_bus_pkg::data_t exp_data, input logic exp_valid);
        accesses.push_back(make_row(name, addr, 8'h00, KIND_READ, exp_data, exp_valid, 4'b0));
    endtask

    task automatic write_row(input string name, input periph_bus_pkg::io_addr_t addr,
                             input periph_bus_pkg::data_t wdata);
        accesses.push_back(make_row(name, addr, wdata, KIND_WRITE, 8'h00, 1'b0, 4'b0));
    endtask

    task automatic mem_row(input string name, input periph_bus_pkg::io_addr_t addr,
                           input logic [3:0] exp_hits);
        accesses.push_back(make_row(name, addr, 8'h00, KIND_MEM, 8'h00, 1'b0, exp_hits));
    endtask

    task automatic apply_row(input access_t row);
        address          = row.addr;
        data             = row.data;
        io_read_n        = (row.kind != KIND_READ);
        io_write_n       = (row.kind != KIND_WRITE);
        address_enable_n = row.aen_n;
        tandy_video      = row.tandy;
        ems_enabled      = row.ems_en;
        ems_base_sel     = row.base_sel;
    endtask

    task automatic check_data(input string name, input periph_bus_pkg::data_t exp,
                              input periph_bus_pkg::data_t act);
        if (act !== exp) begin
            $display("ERROR %s: data expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: valid expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "valid mismatch");
        end
    endtask

    task automatic check_hits(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            $display("ERROR %s: hits expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "window hit mismatch");
        end
    endtask

    task automatic check_enables(input string name, input logic [3:0] exp,
                                 input logic [3:0] act);
        if (act !== exp) begin
            $display("ERROR %s: map enables expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "map enable mismatch");
        end
    endtask

    task automatic check_pages(input string name, input ems_pkg::ems_page_t [3:0] exp,
                               input ems_pkg::ems_page_t [3:0] act);
        if (act !== exp) begin
            $display("ERROR %s: pages expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "map page mismatch");
        end
    endtask

    initial begin
        periph_bus_pkg::data_t lpt_a;
        periph_bus_pkg::data_t page_b;
        periph_bus_pkg::data_t lpt_c;
        periph_bus_pkg::data_t lpt_d;
        access_t               idle;
        access_t               current;
        access_t               done;

        reset            = 1'b1;
        address          = '0;
        data             = '0;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        address_enable_n = 1'b1;
        tandy_video      = 1'b0;
        ems_enabled      = 1'b0;
        ems_base_sel     = 2'd0;
        row_aen_n        = 1'b0;
        row_tandy        = 1'b1;
        row_ems_en       = 1'b1;
        row_base_sel     = 2'd0;
        row_map_en       = 4'b0000;
        row_pages        = '0;

        lpt_a  = 8'($random(seed));
        page_b = 8'($random(seed));
        lpt_c  = 8'($random(seed));
        lpt_d  = 8'($random(seed));

        // Reset values
        read_row("lpt reset", ADDR_LPT, `LPT_RESET, 1'b1);
        read_row("page reset", ADDR_PAGE, `TANDY_PAGE_RESET, 1'b1);
        read_row("nmi reset", ADDR_NMI, `NMI_MASK_RESET, 1'b1);
        for (int k = 0; k < 4; k++) begin
            read_row($sformatf("ems slot %0d reset", k), ADDR_EMS0 + k, 8'hFF, 1'b1);
        end
        mem_row("no hit at A0000 after reset", 20'hA0000, 4'b0000);
        mem_row("no hit at A8000 after reset", 20'hA8000, 4'b0000);

        // Plain registers, read straight after the write
        write_row("lpt write a", ADDR_LPT, lpt_a);
        read_row("lpt read a", ADDR_LPT, lpt_a, 1'b1);
        write_row("page write", ADDR_PAGE, page_b);
        read_row("page read", ADDR_PAGE, page_b, 1'b1);
        write_row("lpt write c", ADDR_LPT, lpt_c);
        mem_row("gap", 20'h00000, 4'b0000);
        read_row("lpt read c", ADDR_LPT, lpt_c, 1'b1);

        // EMS slot 2 map, then its window for each base
        row_map_en[2] = 1'b1;
        row_pages[2]  = 7'h05;
        write_row("ems map slot 2", ADDR_EMS0 + 2, 8'h05);
        read_row("ems read slot 2 mapped", ADDR_EMS0 + 2, 8'h05, 1'b1);
        mem_row("hit base A", 20'hA8000, 4'b0100);
        row_base_sel = 2'd1;
        mem_row("hit base C", 20'hC8000, 4'b0100);
        row_base_sel = 2'd2;
        mem_row("hit base D sel 2", 20'hD8000, 4'b0100);
        row_base_sel = 2'd3;
        mem_row("hit base D sel 3", 20'hD8000, 4'b0100);
        row_base_sel = 2'd0;
        mem_row("no hit outside base A", 20'hC8000, 4'b0000);
        write_row("ems write 90h", ADDR_EMS0 + 2, 8'h90);
        read_row("ems slot 2 unchanged", ADDR_EMS0 + 2, 8'h05, 1'b1);
        // Unmap keeps the stored page
        row_map_en[2] = 1'b0;
        write_row("ems unmap slot 2", ADDR_EMS0 + 2, `EMS_UNMAP_BYTE);
        read_row("ems read slot 2 unmapped", ADDR_EMS0 + 2, 8'hFF, 1'b1);
        mem_row("no hit base A after unmap", 20'hA8000, 4'b0000);
        row_base_sel = 2'd2;
        mem_row("no hit base D after unmap", 20'hD8000, 4'b0000);
        row_base_sel = 2'd0;

        // Cycles that must not decode
        row_tandy = 1'b0;
        read_row("nmi read tandy off", ADDR_NMI, 8'h00, 1'b0);
        write_row("nmi write tandy off", ADDR_NMI, 8'h12);
        row_tandy = 1'b1;
        read_row("nmi unchanged", ADDR_NMI + 3, `NMI_MASK_RESET, 1'b1);
        row_ems_en = 1'b0;
        write_row("ems write disabled", ADDR_EMS0 + 1, 8'h03);
        read_row("ems read disabled", ADDR_EMS0 + 1, 8'h00, 1'b0);
        row_ems_en = 1'b1;
        read_row("ems slot 1 unchanged", ADDR_EMS0 + 1, 8'hFF, 1'b1);
        row_aen_n = 1'b1;
        read_row("lpt read aen high", ADDR_LPT, 8'h00, 1'b0);
        write_row("lpt write aen high", ADDR_LPT, lpt_d);
        row_aen_n = 1'b0;
        read_row("lpt unchanged", ADDR_LPT, lpt_c, 1'b1);

        idle = make_row("flush", 20'h00000, 8'h00, KIND_MEM, 8'h00, 1'b0, 4'b0000);
        max_cycles = accesses.size() + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clock);
        #10;
        reset = 1'b0;

        // Read results come back two cycles after the cycle is applied
        for (int i = 0; i < accesses.size() + 2; i++) begin
            @(posedge clock);
            #10;
            current = (i < accesses.size()) ? accesses[i] : idle;
            apply_row(current);
            in_flight.push_back(current);
            #40;
            check_hits(current.name, current.exp_hits, ems_window_hit);
            if (in_flight.size() == 3) begin
                done = in_flight.pop_front();
                check_valid(done.name, done.exp_valid, data_valid);
                check_data(done.name, done.exp_data, data_out);
                check_enables(done.name, done.exp_enables, ems_map_enable);
                check_pages(done.name, done.exp_pages, ems_page);
            end
        end

        if (uut.u_asserts.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "assertion failures during the run");
        end
    end

endmodule

`default_nettype wire

/* periph_glue_asserts.sv */
//------------------------------
// Peripheral glue assertions
// Read-back timing and window hits
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module periph_glue_asserts (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   io_read_n_i,
    input  periph_bus_pkg::data_t  data_i,
    input  logic                   data_valid_i,
    input  logic [3:0]             window_hit_i
);

    int fail_count = 0;

    // Read data follows a read strobe two edges back
    valid_after_read: assert property (@(posedge clock) disable iff (reset)
        data_valid_i |-> $past(!io_read_n_i, 2))
        else begin
            fail_count++;
            $error("data valid without a read strobe two cycles earlier");
        end

    idle_bus_zero: assert property (@(posedge clock) disable iff (reset)
        !data_valid_i |-> (data_i == '0))
        else begin
            fail_count++;
            $error("data bus not zero while data valid is low");
        end

    // Windows of different slots never overlap
    single_window_hit: assert property (@(posedge clock) disable iff (reset)
        $onehot0(window_hit_i))
        else begin
            fail_count++;
            $error("more than one EMS window hit at once");
        end

endmodule

bind periph_glue_top periph_glue_asserts u_asserts (
    .clock        (clock),
    .reset        (reset),
    .io_read_n_i  (io_read_n_i),
    .data_i       (data_o),
    .data_valid_i (data_valid_o),
    .window_hit_i (ems_window_hit_o)
);

`default_nettype wire

/* periph_glue_top.sv */
//------------------------------
// PC-XT peripheral glue top
// Decode, register and read-back
// pipeline
//------------------------------
`timescale 1ns/100ps
`default_nettype none

module periph_glue_top (
    input  logic                        clock,
    input  logic                        reset,
    input  periph_bus_pkg::io_addr_t    address_i,
    input  periph_bus_pkg::data_t       data_i,
    input  logic                        io_read_n_i,
    input  logic                        io_write_n_i,
    input  logic                        address_enable_n_i,
    input  logic                        tandy_video_i,
    input  logic                        ems_enabled_i,
    input  ems_pkg::ems_base_sel_t      ems_base_sel_i,
    output periph_bus_pkg::data_t       data_o,
    output logic                        data_valid_o,
    output ems_pkg::ems_page_t [3:0]    ems_page_o,
    output logic [3:0]                  ems_map_enable_o,
    output logic [3:0]                  ems_window_hit_o
);

    periph_bus_pkg::periph_dev_t dev;
    ems_pkg::ems_slot_t          slot;
    periph_bus_pkg::data_t       wdata;
    logic                        write;
    logic                        read;
    periph_bus_pkg::data_t       lpt;
    periph_bus_pkg::data_t       tandy_page;
    periph_bus_pkg::data_t       nmi_mask;

    io_decode_stage u_decode (
        .clock              (clock),
        .reset              (reset),
        .address_i          (address_i),
        .data_i             (data_i),
        .io_read_n_i        (io_read_n_i),
        .io_write_n_i       (io_write_n_i),
        .address_enable_n_i (address_enable_n_i),
        .tandy_video_i      (tandy_video_i),
        .ems_enabled_i      (ems_enabled_i),
        .dev_o              (dev),
        .slot_o             (slot),
        .wdata_o            (wdata),
        .write_o            (write),
        .read_o             (read)
    );

    port_register_file u_regs (
        .clock        (clock),
        .reset        (reset),
        .dev_i        (dev),
        .wdata_i      (wdata),
        .write_i      (write),
        .lpt_o        (lpt),
        .tandy_page_o (tandy_page),
        .nmi_mask_o   (nmi_mask)
    );

    ems_map_stage u_ems (
        .clock            (clock),
        .reset            (reset),
        .dev_i            (dev),
        .slot_i           (slot),
        .wdata_i          (wdata),
        .write_i          (write),
        .address_i        (address_i),
        .io_read_n_i      (io_read_n_i),
        .io_write_n_i     (io_write_n_i),
        .ems_base_sel_i   (ems_base_sel_i),
        .ems_page_o       (ems_page_o),
        .ems_map_enable_o (ems_map_enable_o),
        .ems_window_hit_o (ems_window_hit_o)
    );

    readback_stage u_readback (
        .clock            (clock),
        .reset            (reset),
        .dev_i            (dev),
        .slot_i           (slot),
        .read_i           (read),
        .lpt_i            (lpt),
        .tandy_page_i     (tandy_page),
        .nmi_mask_i       (nmi_mask),
        .ems_page_i       (ems_page_o),
        .ems_map_enable_i (ems_map_enable_o),
        .data_o           (data_o),
        .data_valid_o     (data_valid_o)
    );

endmodule

`default_nettype wire

/* readback_stage.sv */
//------------------------------
// Read-back stage
// Selects and registers the byte
// driven onto the chipset bus
//------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module readback_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  periph_bus_pkg::periph_dev_t   dev_i,
    input  ems_pkg::ems_slot_t            slot_i,
    input  logic                          read_i,
    input  periph_bus_pkg::data_t         lpt_i,
    input  periph_bus_pkg::data_t         tandy_page_i,
    input  periph_bus_pkg::data_t         nmi_mask_i,
    input  ems_pkg::ems_page_t [3:0]      ems_page_i,
    input  logic [3:0]                    ems_map_enable_i,
    output periph_bus_pkg::data_t         data_o,
    output logic                          data_valid_o
);

    periph_bus_pkg::data_t rd_byte;

    always_comb begin
        case (dev_i)
            periph_bus_pkg::DEV_EMS: begin
                // Unmapped entries read as FFh
                rd_byte = ems_map_enable_i[slot_i] ? {1'b0, ems_page_i[slot_i]}
                                                   : `EMS_UNMAP_BYTE;
            end
            periph_bus_pkg::DEV_LPT:        rd_byte = lpt_i;
            periph_bus_pkg::DEV_TANDY_PAGE: rd_byte = tandy_page_i;
            periph_bus_pkg::DEV_NMI_MASK:   rd_byte = nmi_mask_i;
            default:                        rd_byte = '0;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end else if (read_i) begin
            data_o       <= rd_byte;
            data_valid_o <= 1'b1;
        end else begin
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* ems_map_stage.sv */
//------------------------------
// EMS page map
// Four map entries and their
// memory window hits
//------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module ems_map_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  periph_bus_pkg::periph_dev_t   dev_i,
    input  ems_pkg::ems_slot_t            slot_i,
    input  periph_bus_pkg::data_t         wdata_i,
    input  logic                          write_i,
    input  periph_bus_pkg::io_addr_t      address_i,
    input  logic                          io_read_n_i,
    input  logic                          io_write_n_i,
    input  ems_pkg::ems_base_sel_t        ems_base_sel_i,
    output ems_pkg::ems_page_t [3:0]      ems_page_o,
    output logic [3:0]                    ems_map_enable_o,
    output logic [3:0]                    ems_window_hit_o
);

    ems_pkg::ems_write_u map_wr;
    logic                ems_write;
    logic [3:0]          base_nibble;
    logic                mem_cycle;

    always_comb begin
        map_wr.raw = wdata_i;
    end

    assign ems_write = write_i && (dev_i == periph_bus_pkg::DEV_EMS);

    // Map update, FFh unmaps, 00h-7Fh maps, the rest is ignored
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ems_page_o       <= '0;
            ems_map_enable_o <= '0;
        end else if (ems_write) begin
            if (map_wr.raw == `EMS_UNMAP_BYTE) begin
                ems_map_enable_o[slot_i] <= 1'b0;
            end else if (!map_wr.map.above) begin
                ems_page_o[slot_i]       <= map_wr.map.page;
                ems_map_enable_o[slot_i] <= 1'b1;
            end
        end
    end

    always_comb begin
        case (ems_base_sel_i)
            2'd0:    base_nibble = `EMS_WIN_A;
            2'd1:    base_nibble = `EMS_WIN_C;
            default: base_nibble = `EMS_WIN_D;
        endcase
    end

    // Only memory cycles hit, any I/O strobe masks the window
    assign mem_cycle = io_read_n_i & io_write_n_i;

    // Slot k covers base + k * 16 KB
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            ems_window_hit_o[k] = mem_cycle && ems_map_enable_o[k] &&
                (address_i[`PERIPH_ADDR_W-1:14] == {base_nibble, 2'(k)});
        end
    end

endmodule

`default_nettype wire

/* port_register_file.sv */
//------------------------------
// Plain port registers
// Printer latch, Tandy page and
// NMI mask
//------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module port_register_file (
    input  logic                         clock,
    input  logic                         reset,
    input  periph_bus_pkg::periph_dev_t  dev_i,
    input  periph_bus_pkg::data_t        wdata_i,
    input  logic                         write_i,
    output periph_bus_pkg::data_t        lpt_o,
    output periph_bus_pkg::data_t        tandy_page_o,
    output periph_bus_pkg::data_t        nmi_mask_o
);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_o        <= `LPT_RESET;
            tandy_page_o <= `TANDY_PAGE_RESET;
            nmi_mask_o   <= `NMI_MASK_RESET;
        end else if (write_i) begin
            case (dev_i)
                periph_bus_pkg::DEV_LPT: begin
                    lpt_o <= wdata_i;
                end
                periph_bus_pkg::DEV_TANDY_PAGE: begin
                    tandy_page_o <= wdata_i;
                end
                periph_bus_pkg::DEV_NMI_MASK: begin
                    // Video page bits are not used here, byte is only stored
                    nmi_mask_o <= wdata_i;
                end
                default: begin
                    // EMS writes go to the map stage
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* io_decode_stage.sv */
//------------------------------
// I/O decode stage
// Registers the bus cycle and the
// device it targets
//------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "periph_defs.svh"

module io_decode_stage (
    input  logic                         clock,
    input  logic                         reset,
    input  periph_bus_pkg::io_addr_t     address_i,
    input  periph_bus_pkg::data_t        data_i,
    input  logic                         io_read_n_i,
    input  logic                         io_write_n_i,
    input  logic                         address_enable_n_i,
    input  logic                         tandy_video_i,
    input  logic                         ems_enabled_i,
    output periph_bus_pkg::periph_dev_t  dev_o,
    output ems_pkg::ems_slot_t           slot_o,
    output periph_bus_pkg::data_t        wdata_o,
    output logic                         write_o,
    output logic                         read_o
);

    logic [15:0]                 port;
    logic                        iorq;
    periph_bus_pkg::periph_dev_t dev_next;

    assign port = address_i[15:0];
    assign iorq = ~io_read_n_i | ~io_write_n_i;

    always_comb begin
        dev_next = periph_bus_pkg::DEV_NONE;
        if (~address_enable_n_i && iorq) begin
            if (ems_enabled_i && ({port[15:2], 2'b00} == `PORT_EMS_BASE)) begin
                dev_next = periph_bus_pkg::DEV_EMS;
            end else if (port == `PORT_LPT) begin
                dev_next = periph_bus_pkg::DEV_LPT;
            end else if (port == `PORT_TANDY_PAGE) begin
                dev_next = periph_bus_pkg::DEV_TANDY_PAGE;
            end else if (tandy_video_i && ({port[15:3], 3'b000} == `PORT_NMI_MASK)) begin
                // A0h-A7h only exists on Tandy
                dev_next = periph_bus_pkg::DEV_NMI_MASK;
            end
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            dev_o   <= periph_bus_pkg::DEV_NONE;
            write_o <= 1'b0;
            read_o  <= 1'b0;
        end else begin
            dev_o   <= dev_next;
            write_o <= ~io_write_n_i && (dev_next != periph_bus_pkg::DEV_NONE);
            read_o  <= ~io_read_n_i && (dev_next != periph_bus_pkg::DEV_NONE);
        end
    end

    always_ff @(posedge clock) begin
        slot_o  <= address_i[1:0];
        wdata_o <= data_i;
    end

endmodule

`default_nettype wire

/* ems_pkg.sv */
//------------------------------
// EMS page map types
// Page number, slot, map write byte
//------------------------------
`default_nettype none

`include "periph_defs.svh"

package ems_pkg;

    typedef logic [6:0] ems_page_t;
    typedef logic [1:0] ems_slot_t;

    // 0 selects A0000h, 1 selects C0000h, others D0000h
    typedef logic [1:0] ems_base_sel_t;

    typedef struct packed {
        logic      above;
        ems_page_t page;
    } ems_map_field_t;

    // Written byte, seen raw or as flag plus page
    typedef union packed {
        logic [`PERIPH_DATA_W-1:0] raw;
        ems_map_field_t            map;
    } ems_write_u;

endpackage

`default_nettype wire

/* periph_bus_pkg.sv */
//------------------------------
// Peripheral I/O bus types
// Address, data byte and target device
//------------------------------
`default_nettype none

`include "periph_defs.svh"

package periph_bus_pkg;

    // Full 20-bit bus address
    typedef logic [`PERIPH_ADDR_W-1:0] io_addr_t;

    typedef logic [`PERIPH_DATA_W-1:0] data_t;

    // Device targeted by an I/O cycle
    typedef enum logic [2:0] {
        DEV_NONE       = 3'd0,
        DEV_EMS        = 3'd1,
        DEV_LPT        = 3'd2,
        DEV_TANDY_PAGE = 3'd3,
        DEV_NMI_MASK   = 3'd4
    } periph_dev_t;

endpackage

`default_nettype wire

/* periph_defs.svh */
//------------------------------
// PC-XT peripheral glue
// Port addresses, EMS window bases,
// bus widths and register reset values
//------------------------------
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// Bus widths
`define PERIPH_DATA_W       8
`define PERIPH_ADDR_W       20

// I/O ports, compared against address bits 15:0
`define PORT_EMS_BASE       16'h0260
`define PORT_LPT            16'h0378
`define PORT_TANDY_PAGE     16'h03DF
`define PORT_NMI_MASK       16'h00A0

// EMS window base nibbles, address bits 19:16
`define EMS_WIN_A           4'hA
`define EMS_WIN_C           4'hC
`define EMS_WIN_D           4'hD

// Register reset values
`define LPT_RESET           8'hFF
`define TANDY_PAGE_RESET    8'h00
`define NMI_MASK_RESET      8'hFF

// Map write byte that unmaps an entry
`define EMS_UNMAP_BYTE      8'hFF

`endif
